//--- rtl/read_collector.sv
// Read word collector
`timescale 1ns/100ps

module read_collector import serial_bus_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       rd_bit,
    input  logic       rd_en,
    input  logic       rd_accept,
    output data_word_t rd_data,
    output logic       rd_data_valid,
    output logic       rd_credit,
    output logic       rd_word_done
);
    localparam int CNT_W = $clog2(DATA_W);

    logic [CNT_W-1:0] bit_cnt;
    data_word_t       shift_sr;
    data_word_t       hold;
    logic             word_in;

    assign word_in      = rd_en && (bit_cnt == CNT_W'(DATA_W-1));
    assign rd_word_done = rd_data_valid && rd_accept;
    assign rd_data      = hold;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            bit_cnt       <= '0;
            rd_data_valid <= 1'b0;
            rd_credit     <= 1'b0;
        end else begin
            if (rd_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (word_in) begin
                rd_data_valid <= 1'b1;
            end else if (rd_word_done) begin
                rd_data_valid <= 1'b0;
            end
            // credit stays up while the holding register is free and nothing is arriving
            rd_credit <= !rd_data_valid && !rd_en && (bit_cnt == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            shift_sr <= {shift_sr[DATA_W-2:0], rd_bit};
        end
        if (word_in) begin
            hold <= {shift_sr[DATA_W-2:0], rd_bit};
        end
    end

endmodule

//--- rtl/serial_bus_pkg.sv
// Serial bus shared definitions
package serial_bus_pkg;

    // data word width, the one fixed word size of the bus
    localparam int DATA_W = 32;

    // header start pattern
    localparam logic [2:0] START_CODE = 3'b111;

    // start code, rw and burst bits
    localparam int HDR_FIXED_BITS = 5;

    // burst length field, n means n+1 words
    localparam int BURST_LEN_W = 4;

    typedef logic [DATA_W-1:0]      data_word_t;
    typedef logic [BURST_LEN_W-1:0] burst_len_t;

endpackage

//--- rtl/serial_bus_top.sv
// Serial memory bus top level
`timescale 1ns/100ps

module serial_bus_top import serial_bus_pkg::*; #(
    parameter int NUM_SLAVES = 4,
    parameter int ADDR_DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  cmd_valid,
    input  logic                  cmd_write,
    input  logic [SLAVE_ID_W-1:0] cmd_slave,
    input  logic [ADDR_W-1:0]     cmd_addr,
    input  burst_len_t            cmd_len,
    output logic                  cmd_ready,
    input  data_word_t            wr_data,
    output logic                  wr_take,
    output data_word_t            rd_data,
    output logic                  rd_data_valid,
    input  logic                  rd_accept,
    output logic                  done
);
    localparam int ADDR_W     = $clog2(ADDR_DEPTH);
    localparam int SLAVE_ID_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

    logic ctrl_bit, ctrl_en, wr_bit, wr_en, last;
    logic wr_credit, rd_bit, rd_en, rd_credit, rd_word_done;
    logic [NUM_SLAVES-1:0] s_ctrl_en, s_wr_en, s_rd_bit, s_rd_en;
    logic [NUM_SLAVES-1:0] s_wr_credit, s_busy, s_rd_credit;

    serial_master #(.NUM_SLAVES(NUM_SLAVES), .ADDR_DEPTH(ADDR_DEPTH)) master0 (
        .clk, .resetn, .cmd_valid, .cmd_write, .cmd_slave, .cmd_addr, .cmd_len,
        .wr_data, .wr_credit, .rd_word_done, .cmd_ready, .wr_take,
        .ctrl_bit, .ctrl_en, .wr_bit, .wr_en, .last, .done
    );

    slave_select #(.NUM_SLAVES(NUM_SLAVES), .ADDR_DEPTH(ADDR_DEPTH)) select0 (
        .clk, .resetn, .ctrl_bit, .ctrl_en, .wr_en, .last,
        .slave_ctrl_en(s_ctrl_en), .slave_wr_en(s_wr_en),
        .slave_rd_bit(s_rd_bit), .slave_rd_en(s_rd_en),
        .slave_wr_credit(s_wr_credit), .slave_busy(s_busy),
        .wr_credit, .rd_bit, .rd_en, .rd_credit, .slave_rd_credit(s_rd_credit)
    );

    for (genvar k = 0; k < NUM_SLAVES; k++) begin : g_slave
        serial_slave #(.NUM_SLAVES(NUM_SLAVES), .ADDR_DEPTH(ADDR_DEPTH)) slave0 (
            .clk, .resetn, .ctrl_bit, .ctrl_en(s_ctrl_en[k]), .wr_bit,
            .wr_en(s_wr_en[k]), .last, .rd_credit(s_rd_credit[k]),
            .rd_bit(s_rd_bit[k]), .rd_en(s_rd_en[k]),
            .wr_credit(s_wr_credit[k]), .busy(s_busy[k])
        );
    end

    read_collector collect0 (
        .clk, .resetn, .rd_bit, .rd_en, .rd_accept,
        .rd_data, .rd_data_valid, .rd_credit, .rd_word_done
    );

endmodule

//--- rtl/serial_master.sv
// Serial bus master
`timescale 1ns/100ps

module serial_master import serial_bus_pkg::*; #(
    parameter int NUM_SLAVES = 4,
    parameter int ADDR_DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  cmd_valid,
    input  logic                  cmd_write,
    input  logic [SLAVE_ID_W-1:0] cmd_slave,
    input  logic [ADDR_W-1:0]     cmd_addr,
    input  burst_len_t            cmd_len,
    input  data_word_t            wr_data,
    input  logic                  wr_credit,
    input  logic                  rd_word_done,
    output logic                  cmd_ready,
    output logic                  wr_take,
    output logic                  ctrl_bit,
    output logic                  ctrl_en,
    output logic                  wr_bit,
    output logic                  wr_en,
    output logic                  last,
    output logic                  done
);
    localparam int ADDR_W     = $clog2(ADDR_DEPTH);
    localparam int SLAVE_ID_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
    localparam int HDR_LEN    = HDR_FIXED_BITS + SLAVE_ID_W + ADDR_W;
    localparam int CNT_W      = $clog2((HDR_LEN > DATA_W) ? HDR_LEN : DATA_W);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_WAIT_CREDIT,
        ST_SEND,
        ST_FINISH
    } state_t;

    state_t             state;
    logic [HDR_LEN-1:0] hdr_sr;
    data_word_t         wr_sr;
    logic [CNT_W-1:0]   bit_cnt;
    burst_len_t         len;
    burst_len_t         word_cnt;
    logic               is_write;
    logic [1:0]         credits;
    logic               spend;
    logic               final_word;

    assign final_word = (word_cnt == len);
    assign spend      = (state == ST_WAIT_CREDIT) && is_write && (credits != 2'd0);

    assign wr_take  = spend;
    assign ctrl_en  = (state == ST_HEADER);
    assign ctrl_bit = hdr_sr[HDR_LEN-1];
    assign wr_en    = (state == ST_SEND);
    assign wr_bit   = wr_sr[DATA_W-1];

    // on reads last covers the whole final word, the slave samples it at the last bit
    assign last = (wr_en && final_word && (bit_cnt == CNT_W'(DATA_W-1)))
               || ((state == ST_WAIT_CREDIT) && !is_write && final_word);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            credits <= 2'd0;
        end else if (state == ST_IDLE) begin
            credits <= 2'd0;
        end else begin
            credits <= credits + 2'(wr_credit) - 2'(spend);
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            cmd_ready <= 1'b0;
            done      <= 1'b0;
            bit_cnt   <= '0;
            word_cnt  <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    cmd_ready <= 1'b1;
                    if (cmd_valid && cmd_ready) begin
                        cmd_ready <= 1'b0;
                        bit_cnt   <= '0;
                        word_cnt  <= '0;
                        state     <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(HDR_LEN-1)) begin
                        state <= ST_WAIT_CREDIT;
                    end
                end
                ST_WAIT_CREDIT: begin
                    if (spend) begin
                        bit_cnt <= '0;
                        state   <= ST_SEND;
                    end else if (!is_write && rd_word_done) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (final_word) begin
                            state <= ST_FINISH;
                        end
                    end
                end
                ST_SEND: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(DATA_W-1)) begin
                        word_cnt <= word_cnt + 1'b1;
                        state    <= final_word ? ST_FINISH : ST_WAIT_CREDIT;
                    end
                end
                ST_FINISH: begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // command and data shift registers
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd_valid && cmd_ready) begin
            hdr_sr   <= {START_CODE, cmd_slave, cmd_write, (cmd_len != '0), cmd_addr};
            is_write <= cmd_write;
            len      <= cmd_len;
        end else if (state == ST_HEADER) begin
            hdr_sr <= hdr_sr << 1;
        end
        if (spend) begin
            wr_sr <= wr_data;
        end else if (state == ST_SEND) begin
            wr_sr <= wr_sr << 1;
        end
    end

endmodule

//--- rtl/serial_slave.sv
// Serial RAM slave
`timescale 1ns/100ps

module serial_slave import serial_bus_pkg::*; #(
    parameter int NUM_SLAVES = 4,
    parameter int ADDR_DEPTH = 256
) (
    input  logic clk,
    input  logic resetn,
    input  logic ctrl_bit,
    input  logic ctrl_en,
    input  logic wr_bit,
    input  logic wr_en,
    input  logic last,
    input  logic rd_credit,
    output logic rd_bit,
    output logic rd_en,
    output logic wr_credit,
    output logic busy
);
    localparam int ADDR_W     = $clog2(ADDR_DEPTH);
    localparam int SLAVE_ID_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
    localparam int HDR_LEN    = HDR_FIXED_BITS + SLAVE_ID_W + ADDR_W;
    localparam int HCNT_W     = $clog2(HDR_LEN);
    localparam int DCNT_W     = $clog2(DATA_W);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_WRITE,
        ST_WRITE_COMMIT,
        ST_READ_LOAD,
        ST_READ_SHIFT
    } state_t;

    state_t              state;
    logic [HDR_LEN-2:0]  hdr_buf;
    logic [HDR_LEN-1:0]  hdr_full;
    logic [HCNT_W-1:0]   hdr_cnt;
    logic [DCNT_W-1:0]   bit_cnt;
    logic [ADDR_W-1:0]   addr;
    logic                burst;
    logic                final_word;
    data_word_t          wr_buf;
    data_word_t          rd_buf;
    data_word_t          mem [ADDR_DEPTH];

    assign hdr_full = {hdr_buf, ctrl_bit};
    assign busy     = (state != ST_IDLE);
    assign rd_en    = (state == ST_READ_SHIFT);
    assign rd_bit   = rd_buf[DATA_W-1];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            hdr_cnt    <= '0;
            bit_cnt    <= '0;
            burst      <= 1'b0;
            final_word <= 1'b0;
            wr_credit  <= 1'b0;
        end else begin
            wr_credit <= 1'b0;
            case (state)
                ST_IDLE: begin
                    hdr_cnt <= '0;
                    if (ctrl_en) begin
                        hdr_cnt <= 1'b1;
                        state   <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    // header bits are back to back, a gap means another slave was picked
                    if (!ctrl_en) begin
                        state <= ST_IDLE;
                    end else if (hdr_cnt == HCNT_W'(HDR_LEN-1)) begin
                        burst   <= hdr_full[ADDR_W];
                        bit_cnt <= '0;
                        if (hdr_full[ADDR_W+1]) begin
                            wr_credit <= 1'b1;
                            state     <= ST_WRITE;
                        end else begin
                            state <= ST_READ_LOAD;
                        end
                    end else begin
                        hdr_cnt <= hdr_cnt + 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (wr_en) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == DCNT_W'(DATA_W-1)) begin
                            final_word <= last || !burst;
                            state      <= ST_WRITE_COMMIT;
                        end
                    end
                end
                ST_WRITE_COMMIT: begin
                    if (final_word) begin
                        state <= ST_IDLE;
                    end else begin
                        wr_credit <= 1'b1;
                        state     <= ST_WRITE;
                    end
                end
                ST_READ_LOAD: begin
                    if (rd_credit) begin
                        bit_cnt <= '0;
                        state   <= ST_READ_SHIFT;
                    end
                end
                ST_READ_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == DCNT_W'(DATA_W-1)) begin
                        state <= (last || !burst) ? ST_IDLE : ST_READ_LOAD;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // header buffer, address, word buffers and RAM
    always_ff @(posedge clk) begin
        if (ctrl_en && (state == ST_IDLE || state == ST_HEADER)) begin
            hdr_buf <= hdr_full[HDR_LEN-2:0];
            if (state == ST_HEADER && hdr_cnt == HCNT_W'(HDR_LEN-1)) begin
                addr <= hdr_full[ADDR_W-1:0];
            end
        end
        if (state == ST_WRITE && wr_en) begin
            wr_buf <= {wr_buf[DATA_W-2:0], wr_bit};
        end
        if (state == ST_WRITE_COMMIT) begin
            mem[addr] <= wr_buf;
            addr      <= addr + 1'b1;
        end
        if (state == ST_READ_LOAD && rd_credit) begin
            rd_buf <= mem[addr];
            addr   <= addr + 1'b1;
        end else if (state == ST_READ_SHIFT) begin
            rd_buf <= rd_buf << 1;
        end
    end

endmodule

//--- rtl/slave_select.sv
// Slave selector
`timescale 1ns/100ps

module slave_select import serial_bus_pkg::*; #(
    parameter int NUM_SLAVES = 4,
    parameter int ADDR_DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  ctrl_bit,
    input  logic                  ctrl_en,
    input  logic                  wr_en,
    input  logic                  last,
    output logic [NUM_SLAVES-1:0] slave_ctrl_en,
    output logic [NUM_SLAVES-1:0] slave_wr_en,
    input  logic [NUM_SLAVES-1:0] slave_rd_bit,
    input  logic [NUM_SLAVES-1:0] slave_rd_en,
    input  logic [NUM_SLAVES-1:0] slave_wr_credit,
    input  logic [NUM_SLAVES-1:0] slave_busy,
    output logic                  wr_credit,
    output logic                  rd_bit,
    output logic                  rd_en,
    input  logic                  rd_credit,
    output logic [NUM_SLAVES-1:0] slave_rd_credit
);
    localparam int ADDR_W     = $clog2(ADDR_DEPTH);
    localparam int SLAVE_ID_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
    localparam int ID_END     = 3 + SLAVE_ID_W;
    localparam int HDR_LEN    = HDR_FIXED_BITS + SLAVE_ID_W + ADDR_W;
    localparam int CNT_W      = $clog2(HDR_LEN + 1);

    logic [ID_END-2:0]     lead_sr;
    logic [CNT_W-1:0]      hdr_cnt;
    logic [SLAVE_ID_W-1:0] sel_id;
    logic                  sel_valid;
    logic                  id_phase;
    logic [NUM_SLAVES-1:0] sel_mask;

    assign id_phase = (hdr_cnt < CNT_W'(ID_END));
    assign sel_mask = sel_valid ? (NUM_SLAVES'(1) << sel_id) : '0;

    // start code and id reach every slave, the rest only the chosen one
    assign slave_ctrl_en   = ctrl_en ? (id_phase ? '1 : sel_mask) : '0;
    assign slave_wr_en     = wr_en ? sel_mask : '0;
    assign slave_rd_credit = rd_credit ? sel_mask : '0;

    assign wr_credit = |(slave_wr_credit & sel_mask);
    assign rd_bit    = |(slave_rd_bit & sel_mask);
    assign rd_en     = |(slave_rd_en & sel_mask);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            hdr_cnt   <= '0;
            lead_sr   <= '0;
            sel_id    <= '0;
            sel_valid <= 1'b0;
        end else begin
            hdr_cnt <= ctrl_en ? hdr_cnt + 1'b1 : '0;
            if (ctrl_en && id_phase) begin
                lead_sr <= {lead_sr[ID_END-3:0], ctrl_bit};
                if (hdr_cnt == CNT_W'(ID_END-1) && lead_sr[ID_END-2 -: 3] == START_CODE) begin
                    sel_id    <= {lead_sr[SLAVE_ID_W-2:0], ctrl_bit};
                    sel_valid <= 1'b1;
                end
            end else if (sel_valid && !ctrl_en && !last && !slave_busy[sel_id]) begin
                sel_valid <= 1'b0;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the serial bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_serial_bus -o tb_serial_bus
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_serial_bus)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

//--- tb/tb_serial_bus.sv
// Serial bus testbench
`timescale 1ns/100ps

module tb_serial_bus import serial_bus_pkg::*;;
    localparam int NUM_SLAVES  = 4;
    localparam int ADDR_DEPTH  = 256;
    localparam int ADDR_W      = $clog2(ADDR_DEPTH);
    localparam int SLAVE_ID_W  = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
    // 8 single, 8 isolation, 2 burst, 3 back-pressure and 60 random commands
    localparam int NUM_CMDS    = 81;
    localparam int CYCLE_LIMIT = 400 * NUM_CMDS + 1000;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic                  cmd_valid;
    logic                  cmd_write;
    logic [SLAVE_ID_W-1:0] cmd_slave;
    logic [ADDR_W-1:0]     cmd_addr;
    burst_len_t            cmd_len;
    logic                  cmd_ready;
    data_word_t            wr_data;
    logic                  wr_take;
    data_word_t            rd_data;
    logic                  rd_data_valid;
    logic                  rd_accept;
    logic                  done;

    // reference memory with one row per slave
    data_word_t ref_mem [NUM_SLAVES][ADDR_DEPTH];
    bit         written_flag [NUM_SLAVES][ADDR_DEPTH];
    data_word_t wq [$];
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         s;
    int         a;
    int         n;
    int         is_wr;
    int         last_s;
    int         last_a;
    int         last_n;

    serial_bus_top #(.NUM_SLAVES(NUM_SLAVES), .ADDR_DEPTH(ADDR_DEPTH)) dut0 (
        .clk, .resetn, .cmd_valid, .cmd_write, .cmd_slave, .cmd_addr, .cmd_len,
        .cmd_ready, .wr_data, .wr_take, .rd_data, .rd_data_valid, .rd_accept, .done
    );

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, a command never finished", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic expect_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_word(input string name, input data_word_t got, input data_word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_count(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic bit range_written(input int sl, input int ad, input int len);
        bit all_set;
        all_set = 1'b1;
        for (int i = 0; i < len; i++) begin
            if (!written_flag[sl][ad+i]) begin
                all_set = 1'b0;
            end
        end
        return all_set;
    endfunction

    // hold the command until the master takes it
    task automatic issue_cmd(input bit wr, input int sl, input int ad, input int len);
        cmd_valid <= 1'b1;
        cmd_write <= wr;
        cmd_slave <= SLAVE_ID_W'(sl);
        cmd_addr  <= ADDR_W'(ad);
        cmd_len   <= burst_len_t'(len - 1);
        do begin
            @(posedge clk);
        end while (!cmd_ready);
        cmd_valid <= 1'b0;
    endtask

    task automatic run_write(input int sl, input int ad, input data_word_t words[$]);
        int idx;
        int takes;
        bit seen_done;
        foreach (words[i]) begin
            ref_mem[sl][ad+i]      = words[i];
            written_flag[sl][ad+i] = 1'b1;
        end
        wr_data <= words[0];
        issue_cmd(1'b1, sl, ad, words.size());
        idx       = 0;
        takes     = 0;
        seen_done = 1'b0;
        while (!seen_done) begin
            @(posedge clk);
            if (wr_take) begin
                takes++;
                idx++;
                if (idx < words.size()) begin
                    wr_data <= words[idx];
                end
            end
            seen_done = done;
        end
        expect_count("wr_take pulses", takes, words.size());
        @(posedge clk);
        expect_bit("done", done, 1'b0);
    endtask

    task automatic run_read(input int sl, input int ad, input int len, input bit bp);
        int got;
        bit seen_done;
        issue_cmd(1'b0, sl, ad, len);
        got       = 0;
        seen_done = 1'b0;
        while (!seen_done) begin
            @(posedge clk);
            if (rd_data_valid && rd_accept) begin
                if (got < len) begin
                    expect_word("rd_data", rd_data, ref_mem[sl][ad+got]);
                end
                got++;
            end
            if (bp) begin
                rd_accept <= (($urandom % 3) != 0);
            end
            seen_done = done;
        end
        rd_accept <= 1'b1;
        expect_count("read words", got, len);
        @(posedge clk);
        expect_bit("done", done, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h7c6a_7c6a));
        resetn    = 1'b0;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_slave = '0;
        cmd_addr  = '0;
        cmd_len   = '0;
        wr_data   = '0;
        rd_accept = 1'b1;

        repeat (16) begin
            @(posedge clk);
            expect_bit("rd_data_valid", rd_data_valid, 1'b0);
            expect_bit("wr_take", wr_take, 1'b0);
            expect_bit("done", done, 1'b0);
            expect_bit("cmd_ready", cmd_ready, 1'b0);
        end
        resetn <= 1'b1;
        @(posedge clk);
        expect_bit("rd_data_valid", rd_data_valid, 1'b0);
        expect_bit("wr_take", wr_take, 1'b0);
        expect_bit("done", done, 1'b0);
        expect_bit("cmd_ready", cmd_ready, 1'b0);
        @(posedge clk);
        expect_bit("cmd_ready", cmd_ready, 1'b1);

        // single word per slave
        for (int k = 0; k < NUM_SLAVES; k++) begin
            a = $urandom % ADDR_DEPTH;
            wq.delete();
            wq.push_back($urandom);
            run_write(k, a, wq);
            run_read(k, a, 1, 1'b0);
        end

        // different words at the same address in every slave
        for (int k = 0; k < NUM_SLAVES; k++) begin
            wq.delete();
            wq.push_back({8'(k + 1), 24'($urandom)});
            run_write(k, 90, wq);
        end
        for (int k = 0; k < NUM_SLAVES; k++) begin
            run_read(k, 90, 1, 1'b0);
        end

        // full 16 word burst
        wq.delete();
        repeat (16) wq.push_back($urandom);
        run_write(1, 64, wq);
        run_read(1, 64, 16, 1'b0);

        // reads with rd_accept dropped at random
        run_read(1, 64, 16, 1'b1);
        wq.delete();
        repeat (9) wq.push_back($urandom);
        run_write(3, 240, wq);
        run_read(3, 240, 9, 1'b1);
        last_s = 3;
        last_a = 240;
        last_n = 9;

        // random mix with reads only of written ranges
        repeat (60) begin
            s     = $urandom % NUM_SLAVES;
            n     = $urandom % 16 + 1;
            a     = $urandom % (ADDR_DEPTH - n + 1);
            is_wr = $urandom % 2;
            // an unwritten range reads back the latest write instead
            if (!is_wr && !range_written(s, a, n)) begin
                s = last_s;
                a = last_a;
                n = last_n;
            end
            if (is_wr) begin
                wq.delete();
                repeat (n) wq.push_back($urandom);
                run_write(s, a, wq);
                last_s = s;
                last_a = a;
                last_n = n;
            end else begin
                run_read(s, a, n, 1'b0);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/serial_bus_pkg.sv
rtl/serial_master.sv
rtl/slave_select.sv
rtl/serial_slave.sv
rtl/read_collector.sv
rtl/serial_bus_top.sv
tb/tb_serial_bus.sv
